// File: design/noc_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shared NoC definitions for the dummy tile routers
// Router sizing, port directions, coordinates, headers, flits
// and the valid/ready link structs of the narrow and wide channels
//////////////////////////////////////////////////////////////////////

package noc_pkg;

  //////////////////////////////////////////////////////////////////////
  // Router sizing
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned NumDirs     = 5;   // North, East, South, West, Eject
  localparam int unsigned InFifoDepth = 2;
  localparam int unsigned InFifoPtrW  = (InFifoDepth > 1) ? $clog2(InFifoDepth) : 1;
  localparam int unsigned InFifoCntW  = $clog2(InFifoDepth + 1);
  localparam int unsigned CoordW      = 3;
  localparam int unsigned NarrowDataW = 32;
  localparam int unsigned WideDataW   = 256;

  // Port index of a router
  typedef enum logic [2:0] {
    North = 3'd0,
    East  = 3'd1,
    South = 3'd2,
    West  = 3'd3,
    Eject = 3'd4
  } route_dir_e;

  //////////////////////////////////////////////////////////////////////
  // Header and flits
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [CoordW-1:0] x;
    logic [CoordW-1:0] y;
  } id_t;

  typedef struct packed {
    id_t  dst_id;
    id_t  src_id;
    logic last;  // Closes the packet and releases the output lock
  } hdr_t;

  // Request and response headers with small payloads
  typedef struct packed {
    hdr_t                   hdr;
    logic [NarrowDataW-1:0] data;
  } narrow_flit_t;

  // Bulk data
  typedef struct packed {
    hdr_t                 hdr;
    logic [WideDataW-1:0] data;
  } wide_flit_t;

  //////////////////////////////////////////////////////////////////////
  // Links
  //////////////////////////////////////////////////////////////////////

  // Sender drives valid and flit, receiver drives ready
  typedef struct packed {
    logic         valid;
    logic         ready;
    narrow_flit_t flit;
  } narrow_link_t;

  typedef struct packed {
    logic       valid;
    logic       ready;
    wide_flit_t flit;
  } wide_link_t;

endpackage : noc_pkg

// File: design/noc_in_fifo.sv
//////////////////////////////////////////////////////////////////////
// Router input buffer (decode stage)
// Circular flit buffer with XY route decode of the head flit
//////////////////////////////////////////////////////////////////////

module noc_in_fifo #(
  parameter type flit_t = noc_pkg::narrow_flit_t
) (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  noc_pkg::id_t                id_i,         // Own tile coordinate
  // Upstream link
  input  logic                        valid_i,
  input  flit_t                       flit_i,
  output logic                        ready_o,
  // Towards the allocator
  output logic                        head_valid_o,
  output flit_t                       head_flit_o,
  output logic [noc_pkg::NumDirs-1:0] route_req_o,  // One-hot output request
  input  logic                        pop_i
);

  flit_t                          mem_q [noc_pkg::InFifoDepth];
  logic [noc_pkg::InFifoPtrW-1:0] wr_ptr_q, rd_ptr_q;
  logic [noc_pkg::InFifoCntW-1:0] count_q;
  logic                           push, pop;
  noc_pkg::id_t                   dst_id;

  function automatic logic [noc_pkg::InFifoPtrW-1:0] next_ptr(
    input logic [noc_pkg::InFifoPtrW-1:0] ptr
  );
    if (ptr == noc_pkg::InFifoDepth - 1) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign ready_o      = (count_q != noc_pkg::InFifoDepth);  // State only
  assign head_valid_o = (count_q != '0);
  assign head_flit_o  = mem_q[rd_ptr_q];

  assign push = valid_i && ready_o;
  assign pop  = pop_i && head_valid_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (pop) rd_ptr_q <= next_ptr(rd_ptr_q);
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Flit storage
  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_ptr_q] <= flit_i;
  end

  // XY routing, x first, every flit carries the header
  assign dst_id = head_flit_o.hdr.dst_id;

  always_comb begin
    route_req_o = '0;
    if (dst_id.x < id_i.x) begin
      route_req_o[noc_pkg::West] = 1'b1;
    end else if (dst_id.x > id_i.x) begin
      route_req_o[noc_pkg::East] = 1'b1;
    end else if (dst_id.y > id_i.y) begin
      route_req_o[noc_pkg::North] = 1'b1;
    end else if (dst_id.y < id_i.y) begin
      route_req_o[noc_pkg::South] = 1'b1;
    end else begin
      route_req_o[noc_pkg::Eject] = 1'b1;  // Addressed to this tile
    end
  end

endmodule : noc_in_fifo

// File: design/noc_switch_alloc.sv
//////////////////////////////////////////////////////////////////////
// Switch allocator (execute stage)
// Round-robin arbiter per output, locked from head to last flit
//////////////////////////////////////////////////////////////////////

module noc_switch_alloc (
  input  logic                                             clk_i,
  input  logic                                             rst_n_i,
  input  logic [noc_pkg::NumDirs-1:0][noc_pkg::NumDirs-1:0] req_i,  // [input][output]
  input  logic [noc_pkg::NumDirs-1:0]                      head_valid_i,
  input  logic [noc_pkg::NumDirs-1:0]                      head_last_i,
  input  logic [noc_pkg::NumDirs-1:0]                      out_ready_i,
  output logic [noc_pkg::NumDirs-1:0]                      pop_o,        // Per input
  output noc_pkg::route_dir_e [noc_pkg::NumDirs-1:0]       sel_o,        // Per output
  output logic [noc_pkg::NumDirs-1:0]                      out_valid_o   // Per output
);

  logic [noc_pkg::NumDirs-1:0]                       lock_q;
  noc_pkg::route_dir_e [noc_pkg::NumDirs-1:0]        owner_q;
  noc_pkg::route_dir_e [noc_pkg::NumDirs-1:0]        rr_ptr_q;
  logic [noc_pkg::NumDirs-1:0][noc_pkg::NumDirs-1:0] out_req;  // [output][input]
  logic [noc_pkg::NumDirs-1:0]                       found;

  function automatic noc_pkg::route_dir_e next_dir(input noc_pkg::route_dir_e dir);
    return noc_pkg::route_dir_e'((int'(dir) + 1) % noc_pkg::NumDirs);
  endfunction

  // Only inputs with a flit at the head compete
  always_comb begin
    for (int o = 0; o < noc_pkg::NumDirs; o++) begin
      for (int i = 0; i < noc_pkg::NumDirs; i++) begin
        out_req[o][i] = req_i[i][o] && head_valid_i[i];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Grant selection
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    int unsigned idx;
    idx   = 0;
    found = '0;
    for (int o = 0; o < noc_pkg::NumDirs; o++) begin
      sel_o[o] = noc_pkg::North;
      if (lock_q[o]) begin
        sel_o[o] = owner_q[o];  // Packet in flight keeps the output
        found[o] = out_req[o][owner_q[o]];
      end else begin
        // Scan backwards so the input nearest the pointer wins
        for (int k = noc_pkg::NumDirs - 1; k >= 0; k--) begin
          idx = (int'(rr_ptr_q[o]) + k) % noc_pkg::NumDirs;
          if (out_req[o][idx]) begin
            sel_o[o] = noc_pkg::route_dir_e'(idx);
            found[o] = 1'b1;
          end
        end
      end
      out_valid_o[o] = found[o] && out_ready_i[o];
    end
  end

  // One-hot requests mean an input wins at most one output
  always_comb begin
    pop_o = '0;
    for (int o = 0; o < noc_pkg::NumDirs; o++) begin
      if (out_valid_o[o]) pop_o[sel_o[o]] = 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Lock and pointer state
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lock_q <= '0;
      for (int o = 0; o < noc_pkg::NumDirs; o++) begin
        owner_q[o]  <= noc_pkg::North;
        rr_ptr_q[o] <= noc_pkg::North;
      end
    end else begin
      for (int o = 0; o < noc_pkg::NumDirs; o++) begin
        if (out_valid_o[o]) begin
          lock_q[o]   <= !head_last_i[sel_o[o]];  // Released by the last flit
          owner_q[o]  <= sel_o[o];
          rr_ptr_q[o] <= next_dir(sel_o[o]);
        end
      end
    end
  end

endmodule : noc_switch_alloc

// File: design/noc_out_reg.sv
//////////////////////////////////////////////////////////////////////
// Router output register slice (result stage)
//////////////////////////////////////////////////////////////////////

module noc_out_reg #(
  parameter type flit_t = noc_pkg::narrow_flit_t
) (
  input  logic  clk_i,
  input  logic  rst_n_i,
  // From the crossbar
  input  logic  valid_i,
  input  flit_t flit_i,
  output logic  ready_o,
  // Downstream link
  output logic  valid_o,
  output flit_t flit_o,
  input  logic  ready_i
);

  logic  valid_q;
  flit_t flit_q;

  // Empty, or the held flit leaves this cycle
  assign ready_o = !valid_q || ready_i;

  assign valid_o = valid_q;
  assign flit_o  = flit_q;

  // Valid only drops after a transfer, so the flit stays stable
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) flit_q <= flit_i;
  end

endmodule : noc_out_reg

// File: design/noc_router.sv
//////////////////////////////////////////////////////////////////////
// Five-port XY router
// Input buffers, switch allocator, crossbar and output registers
//////////////////////////////////////////////////////////////////////

module noc_router #(
  parameter type flit_t = noc_pkg::narrow_flit_t
) (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  noc_pkg::id_t                id_i,
  // Incoming links, indexed by direction
  input  logic [noc_pkg::NumDirs-1:0] in_valid_i,
  input  flit_t [noc_pkg::NumDirs-1:0] in_flit_i,
  output logic [noc_pkg::NumDirs-1:0] in_ready_o,
  // Outgoing links, indexed by direction
  output logic [noc_pkg::NumDirs-1:0] out_valid_o,
  output flit_t [noc_pkg::NumDirs-1:0] out_flit_o,
  input  logic [noc_pkg::NumDirs-1:0] out_ready_i
);

  logic [noc_pkg::NumDirs-1:0]                       head_valid;
  logic [noc_pkg::NumDirs-1:0]                       head_last;
  flit_t [noc_pkg::NumDirs-1:0]                      head_flit;
  logic [noc_pkg::NumDirs-1:0][noc_pkg::NumDirs-1:0] route_req;  // [input][output]
  logic [noc_pkg::NumDirs-1:0]                       pop;
  noc_pkg::route_dir_e [noc_pkg::NumDirs-1:0]        sel;
  logic [noc_pkg::NumDirs-1:0]                       xbar_valid;
  flit_t [noc_pkg::NumDirs-1:0]                      xbar_flit;
  logic [noc_pkg::NumDirs-1:0]                       out_reg_ready;

  //////////////////////////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////////////////////////

  for (genvar d = 0; d < noc_pkg::NumDirs; d++) begin : gen_in
    noc_in_fifo #(
      .flit_t(flit_t)
    ) i_in_fifo (
      .clk_i,
      .rst_n_i,
      .id_i,
      .valid_i     (in_valid_i[d]),
      .flit_i      (in_flit_i[d]),
      .ready_o     (in_ready_o[d]),
      .head_valid_o(head_valid[d]),
      .head_flit_o (head_flit[d]),
      .route_req_o (route_req[d]),
      .pop_i       (pop[d])
    );

    assign head_last[d] = head_flit[d].hdr.last;
  end

  //////////////////////////////////////////////////////////////////////
  // Execute
  //////////////////////////////////////////////////////////////////////

  noc_switch_alloc i_switch_alloc (
    .clk_i,
    .rst_n_i,
    .req_i       (route_req),
    .head_valid_i(head_valid),
    .head_last_i (head_last),
    .out_ready_i (out_reg_ready),
    .pop_o       (pop),
    .sel_o       (sel),
    .out_valid_o (xbar_valid)
  );

  // Crossbar
  always_comb begin
    for (int o = 0; o < noc_pkg::NumDirs; o++) begin
      xbar_flit[o] = head_flit[sel[o]];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Result
  //////////////////////////////////////////////////////////////////////

  for (genvar d = 0; d < noc_pkg::NumDirs; d++) begin : gen_out
    noc_out_reg #(
      .flit_t(flit_t)
    ) i_out_reg (
      .clk_i,
      .rst_n_i,
      .valid_i(xbar_valid[d]),
      .flit_i (xbar_flit[d]),
      .ready_o(out_reg_ready[d]),
      .valid_o(out_valid_o[d]),
      .flit_o (out_flit_o[d]),
      .ready_i(out_ready_i[d])
    );
  end

endmodule : noc_router

// File: design/spu_dummy_tile.sv
//////////////////////////////////////////////////////////////////////
// Dummy mesh tile without a cluster
// Narrow and wide routers forwarding between West and North
//////////////////////////////////////////////////////////////////////

module spu_dummy_tile (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  noc_pkg::id_t          id_i,
  // Narrow channel
  input  noc_pkg::narrow_link_t narrow_west_i,
  output noc_pkg::narrow_link_t narrow_west_o,
  input  noc_pkg::narrow_link_t narrow_north_i,
  output noc_pkg::narrow_link_t narrow_north_o,
  // Wide channel
  input  noc_pkg::wide_link_t   wide_west_i,
  output noc_pkg::wide_link_t   wide_west_o,
  input  noc_pkg::wide_link_t   wide_north_i,
  output noc_pkg::wide_link_t   wide_north_o
);

  logic [noc_pkg::NumDirs-1:0]                narrow_in_valid, narrow_in_ready;
  logic [noc_pkg::NumDirs-1:0]                narrow_out_valid, narrow_out_ready;
  noc_pkg::narrow_flit_t [noc_pkg::NumDirs-1:0] narrow_in_flit, narrow_out_flit;
  logic [noc_pkg::NumDirs-1:0]                wide_in_valid, wide_in_ready;
  logic [noc_pkg::NumDirs-1:0]                wide_out_valid, wide_out_ready;
  noc_pkg::wide_flit_t [noc_pkg::NumDirs-1:0]   wide_in_flit, wide_out_flit;

  //////////////////////////////////////////////////////////////////////
  // Narrow router
  //////////////////////////////////////////////////////////////////////

  noc_router #(
    .flit_t(noc_pkg::narrow_flit_t)
  ) i_narrow_router (
    .clk_i,
    .rst_n_i,
    .id_i,
    .in_valid_i (narrow_in_valid),
    .in_flit_i  (narrow_in_flit),
    .in_ready_o (narrow_in_ready),
    .out_valid_o(narrow_out_valid),
    .out_flit_o (narrow_out_flit),
    .out_ready_i(narrow_out_ready)
  );

  always_comb begin
    // East, South and Eject have no neighbour here
    narrow_in_valid  = '0;
    narrow_in_flit   = '0;
    narrow_out_ready = '0;
    narrow_in_valid[noc_pkg::West]   = narrow_west_i.valid;
    narrow_in_flit[noc_pkg::West]    = narrow_west_i.flit;
    narrow_out_ready[noc_pkg::West]  = narrow_west_i.ready;  // Ready for our outgoing flits
    narrow_in_valid[noc_pkg::North]  = narrow_north_i.valid;
    narrow_in_flit[noc_pkg::North]   = narrow_north_i.flit;
    narrow_out_ready[noc_pkg::North] = narrow_north_i.ready;
  end

  assign narrow_west_o  = '{valid: narrow_out_valid[noc_pkg::West],
                            ready: narrow_in_ready[noc_pkg::West],
                            flit:  narrow_out_flit[noc_pkg::West]};
  assign narrow_north_o = '{valid: narrow_out_valid[noc_pkg::North],
                            ready: narrow_in_ready[noc_pkg::North],
                            flit:  narrow_out_flit[noc_pkg::North]};

  //////////////////////////////////////////////////////////////////////
  // Wide router
  //////////////////////////////////////////////////////////////////////

  noc_router #(
    .flit_t(noc_pkg::wide_flit_t)
  ) i_wide_router (
    .clk_i,
    .rst_n_i,
    .id_i,
    .in_valid_i (wide_in_valid),
    .in_flit_i  (wide_in_flit),
    .in_ready_o (wide_in_ready),
    .out_valid_o(wide_out_valid),
    .out_flit_o (wide_out_flit),
    .out_ready_i(wide_out_ready)
  );

  always_comb begin
    wide_in_valid  = '0;  // Tied off like the narrow side
    wide_in_flit   = '0;
    wide_out_ready = '0;
    wide_in_valid[noc_pkg::West]   = wide_west_i.valid;
    wide_in_flit[noc_pkg::West]    = wide_west_i.flit;
    wide_out_ready[noc_pkg::West]  = wide_west_i.ready;
    wide_in_valid[noc_pkg::North]  = wide_north_i.valid;
    wide_in_flit[noc_pkg::North]   = wide_north_i.flit;
    wide_out_ready[noc_pkg::North] = wide_north_i.ready;
  end

  assign wide_west_o  = '{valid: wide_out_valid[noc_pkg::West],
                          ready: wide_in_ready[noc_pkg::West],
                          flit:  wide_out_flit[noc_pkg::West]};
  assign wide_north_o = '{valid: wide_out_valid[noc_pkg::North],
                          ready: wide_in_ready[noc_pkg::North],
                          flit:  wide_out_flit[noc_pkg::North]};

endmodule : spu_dummy_tile

// File: verification/tb_noc_scoreboard.svh
//////////////////////////////////////////////////////////////////////
// Reference XY routing model of the tile at (TileX, TileY)
// Expected flit queues keyed by channel, input side and output side
//////////////////////////////////////////////////////////////////////

`ifndef TB_NOC_SCOREBOARD_SVH
`define TB_NOC_SCOREBOARD_SVH

noc_pkg::wide_flit_t exp_q [8][$];                 // [ch*4 + in*2 + out]
int                  open_src [4] = '{default: -1};  // Source of the open packet per output

function automatic string chan_name(int ch);
  return (ch == 0) ? "narrow" : "wide";
endfunction

// Neighbour coordinates where side 0 is West and side 1 is North
function automatic noc_pkg::id_t side_id(int side);
  noc_pkg::id_t id;
  id.x = 3'((side == 0) ? TileX - 1 : TileX);
  id.y = 3'((side == 0) ? TileY : TileY + 1);
  return id;
endfunction

// X before Y with -1 marking a tied-off port
function automatic int xy_side(noc_pkg::id_t dst);
  if (dst.x < TileX) return 0;
  if (dst.x == TileX && dst.y > TileY) return 1;
  return -1;
endfunction

task automatic expect_flit(int ch, int in_side, noc_pkg::wide_flit_t f);
  int out_side;
  out_side = xy_side(f.hdr.dst_id);
  if (out_side < 0) begin
    other_errs++;
    $display("ERROR: stimulus addressed a tied-off port, destination %h", f.hdr.dst_id);
  end else begin
    exp_q[ch*4 + in_side*2 + out_side].push_back(f);
  end
endtask

task automatic check_flit(int ch, int out_side, noc_pkg::wide_flit_t f);
  int                  in_side;
  int                  po;
  noc_pkg::wide_flit_t exp_f;
  in_side = (f.hdr.src_id == side_id(0)) ? 0 : (f.hdr.src_id == side_id(1)) ? 1 : -1;
  po      = ch*2 + out_side;
  if (in_side < 0 || exp_q[ch*4 + in_side*2 + out_side].size() == 0) begin
    other_errs++;
    $display("ERROR: unexpected flit on %s output %0d from source %h",
             chan_name(ch), out_side, f.hdr.src_id);
  end else begin
    if (open_src[po] >= 0 && open_src[po] != in_side) begin
      order_errs++;
      $display("MISMATCH packet_integrity: expected source %0d, actual source %0d",
               open_src[po], in_side);
    end
    open_src[po] = f.hdr.last ? -1 : in_side;  // Closed by the last flit
    exp_f = exp_q[ch*4 + in_side*2 + out_side].pop_front();
    if (exp_f !== f) begin
      mismatch_errs++;
      $display("MISMATCH %s_routing: expected %h, actual %h", chan_name(ch), exp_f, f);
    end
  end
endtask

task automatic check_leftovers();
  for (int k = 0; k < 8; k++) begin
    if (exp_q[k].size() != 0) begin
      other_errs++;
      $display("ERROR: %0d %s flits from input %0d to output %0d were never delivered",
               exp_q[k].size(), chan_name(k / 4), (k / 2) % 2, k % 2);
    end
  end
endtask

`endif

// File: verification/tb_spu_tile.sv
//////////////////////////////////////////////////////////////////////
// Testbench for the dummy mesh tile
// Random narrow and wide packets from West and North with
// random back-pressure, checked against an XY routing model
//////////////////////////////////////////////////////////////////////

module tb_spu_tile;

  localparam int TileX       = 2;
  localparam int TileY       = 2;
  localparam int NumLinks    = 4;  // Narrow West, narrow North, wide West, wide North
  localparam int PktsPerLink = 24;

  logic                  clk, rst_n;
  noc_pkg::id_t          tile_id;
  noc_pkg::narrow_link_t narrow_west_i, narrow_west_o, narrow_north_i, narrow_north_o;
  noc_pkg::wide_link_t   wide_west_i, wide_west_o, wide_north_i, wide_north_o;
  integer                seed;
  int                    mismatch_errs, order_errs, other_errs;
  int                    total_flits, rx_count, cycle_cnt, cycle_limit;
  int                    pkt_len [NumLinks][PktsPerLink];
  int                    pkt_idx [NumLinks], flit_idx [NumLinks], stall_left [NumLinks];
  logic                  offer_valid [NumLinks], out_ready [NumLinks];
  logic                  in_rdy [NumLinks], out_vld [NumLinks];
  noc_pkg::hdr_t         offer_hdr [NumLinks];
  noc_pkg::id_t          pkt_dst [NumLinks];
  logic [255:0]          offer_data [NumLinks];
  noc_pkg::wide_flit_t   out_flit [NumLinks];

  `include "tb_noc_scoreboard.svh"

  spu_dummy_tile dut_i (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .id_i          (tile_id),
    .narrow_west_i (narrow_west_i),
    .narrow_west_o (narrow_west_o),
    .narrow_north_i(narrow_north_i),
    .narrow_north_o(narrow_north_o),
    .wide_west_i   (wide_west_i),
    .wide_west_o   (wide_west_o),
    .wide_north_i  (wide_north_i),
    .wide_north_o  (wide_north_o)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    if (rst_n) begin
      cycle_cnt++;
      if (cycle_cnt > cycle_limit) begin
        $display("ERROR: timeout after %0d cycles with %0d flits outstanding",
                 cycle_cnt, total_flits - rx_count);
        $display("Errors: mismatch %0d, order %0d, other %0d, timeout 1",
                 mismatch_errs, order_errs, other_errs);
        $display("CHECKS FAILED");
        $finish;
      end
    end
  end

  function automatic noc_pkg::narrow_link_t narrow_link(int l);
    return '{valid: offer_valid[l], ready: out_ready[l],
             flit: '{hdr: offer_hdr[l], data: offer_data[l][noc_pkg::NarrowDataW-1:0]}};
  endfunction

  function automatic noc_pkg::wide_link_t wide_link(int l);
    return '{valid: offer_valid[l], ready: out_ready[l],
             flit: '{hdr: offer_hdr[l], data: offer_data[l]}};
  endfunction

  ////////////////////////////////////////////////////////////////////
  // Stimulus and sampling
  ////////////////////////////////////////////////////////////////////

  task automatic drive_inputs();
    int r;
    for (int l = 0; l < NumLinks; l++) begin
      r = $random(seed);
      if (!offer_valid[l] && pkt_idx[l] < PktsPerLink && r[1:0] != 2'b00) begin
        if (flit_idx[l] == 0) begin  // New packet toward West or North only
          if (r[2]) pkt_dst[l] = '{x: 3'(r[3]), y: r[6:4]};
          else pkt_dst[l] = '{x: 3'(TileX), y: 3'(TileY + 1 + r[6:4] % 5)};
        end
        offer_hdr[l] = '{dst_id: pkt_dst[l], src_id: side_id(l % 2),
                         last: (flit_idx[l] + 1 == pkt_len[l][pkt_idx[l]])};
        for (int w = 0; w < 8; w++) offer_data[l][w*32 +: 32] = $random(seed);
        if (l < 2) offer_data[l][255:32] = '0;  // Narrow payload
        offer_valid[l] = 1'b1;
      end
      if (stall_left[l] > 0) begin
        stall_left[l]--;
      end else if (r[10:8] == 3'd0) begin
        stall_left[l] = 1 + r[14:12];  // Back-pressure stretch
      end
      out_ready[l] = (stall_left[l] == 0);
    end
    narrow_west_i  = narrow_link(0);
    narrow_north_i = narrow_link(1);
    wide_west_i    = wide_link(2);
    wide_north_i   = wide_link(3);
  endtask

  task automatic read_links();
    in_rdy   = '{narrow_west_o.ready, narrow_north_o.ready, wide_west_o.ready, wide_north_o.ready};
    out_vld  = '{narrow_west_o.valid, narrow_north_o.valid, wide_west_o.valid, wide_north_o.valid};
    out_flit[0] = '{hdr: narrow_west_o.flit.hdr, data: 256'(narrow_west_o.flit.data)};
    out_flit[1] = '{hdr: narrow_north_o.flit.hdr, data: 256'(narrow_north_o.flit.data)};
    out_flit[2] = wide_west_o.flit;
    out_flit[3] = wide_north_o.flit;
  endtask

  // Sampled at the falling edge, so both sides of every handshake are settled
  task automatic step();
    noc_pkg::wide_flit_t f;
    @(posedge clk);
    #1;
    drive_inputs();
    @(negedge clk);
    read_links();
    for (int l = 0; l < NumLinks; l++) begin
      if (offer_valid[l] && in_rdy[l]) begin
        f.hdr  = offer_hdr[l];
        f.data = offer_data[l];
        expect_flit(l / 2, l % 2, f);
        offer_valid[l] = 1'b0;
        flit_idx[l]    = offer_hdr[l].last ? 0 : flit_idx[l] + 1;
        if (offer_hdr[l].last) pkt_idx[l]++;
      end
      if (out_ready[l] && out_vld[l]) begin
        check_flit(l / 2, l % 2, out_flit[l]);
        rx_count++;
      end
    end
  endtask

  initial begin
    seed    = 32'hfbcb;
    clk     = 1'b0;
    rst_n   = 1'b0;
    tile_id = '{x: 3'(TileX), y: 3'(TileY)};
    for (int l = 0; l < NumLinks; l++) begin
      offer_valid[l] = 1'b0;
      out_ready[l]   = 1'b1;
      offer_hdr[l]   = '0;
      offer_data[l]  = '0;
      for (int p = 0; p < PktsPerLink; p++) begin
        pkt_len[l][p] = 1 + ($random(seed) & 3);
        total_flits += pkt_len[l][p];
      end
    end
    narrow_west_i  = narrow_link(0);
    narrow_north_i = narrow_link(1);
    wide_west_i    = wide_link(2);
    wide_north_i   = wide_link(3);
    cycle_limit    = 40 * total_flits + 200;
    repeat (2) @(posedge clk);
    #1 rst_n = 1'b1;
    @(negedge clk);
    read_links();
    for (int l = 0; l < NumLinks; l++) begin
      if (out_vld[l] !== 1'b0 || in_rdy[l] !== 1'b1) begin
        mismatch_errs++;
        $display(
          "MISMATCH reset_state: link %0d expected valid 0 ready 1, actual valid %b ready %b",
          l, out_vld[l], in_rdy[l]);
      end
    end
    while (rx_count < total_flits) step();
    repeat (20) step();  // Room for any duplicated flit to show up
    check_leftovers();
    $display("Errors: mismatch %0d, order %0d, other %0d", mismatch_errs, order_errs, other_errs);
    if (mismatch_errs + order_errs + other_errs == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule : tb_spu_tile

// File: vlog.f
+incdir+verification
design/noc_pkg.sv
design/noc_in_fifo.sv
design/noc_switch_alloc.sv
design/noc_out_reg.sv
design/noc_router.sv
design/spu_dummy_tile.sv
verification/tb_spu_tile.sv

// File: Bender.yml
package:
  name: spu_dummy_tile

sources:
  - files:
      - design/noc_pkg.sv
      - design/noc_in_fifo.sv
      - design/noc_switch_alloc.sv
      - design/noc_out_reg.sv
      - design/noc_router.sv
      - design/spu_dummy_tile.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_spu_tile.sv
